// File: verilog/amber_arch_pkg.sv
`default_nettype none

package amber_arch_pkg;

    // --------------------
    // Datapath widths
    // --------------------
    typedef logic [47:0] addr_t;
    typedef logic [23:0] data_t;
    typedef logic [7:0]  opc_t;

    // --------------------
    // Opcodes seen by the mode logic
    // --------------------
    // Software interrupt, enters kernel mode
    localparam opc_t OPC_SWI  = 8'h70;
    // Supervisor return, drops to user mode
    localparam opc_t OPC_SRET = 8'h71;

    // --------------------
    // PCC reset window
    // --------------------
    // 4K words from address 0
    localparam addr_t PCC_LEN_RESET   = 48'd4096;
    localparam data_t PCC_PERMS_RESET = 24'd4;
    // Execute permission bit in the perms field
    localparam int    PERM_X_BIT      = 2;

endpackage

`default_nettype wire

// File: verilog/amber_csr_pkg.sv
`default_nettype none

package amber_csr_pkg;

    typedef logic [7:0] csr_idx_t;

    // --------------------
    // CSR index map
    // --------------------
    localparam csr_idx_t CSR_IDX_STATUS      = 8'h00;
    localparam csr_idx_t CSR_IDX_PCC_BASE_LO = 8'h10;
    localparam csr_idx_t CSR_IDX_PCC_BASE_HI = 8'h11;
    localparam csr_idx_t CSR_IDX_PCC_LEN_LO  = 8'h12;
    localparam csr_idx_t CSR_IDX_PCC_LEN_HI  = 8'h13;
    localparam csr_idx_t CSR_IDX_PCC_CUR_LO  = 8'h14;
    localparam csr_idx_t CSR_IDX_PCC_CUR_HI  = 8'h15;
    localparam csr_idx_t CSR_IDX_PCC_PERMS   = 8'h16;
    localparam csr_idx_t CSR_IDX_PCC_ATTR    = 8'h17;
    localparam csr_idx_t CSR_IDX_PCC_TAG     = 8'h18;

    // --------------------
    // PCC write strobes
    // --------------------
    // One strobe per PCC CSR, bit order follows the index map
    typedef logic [8:0] pcc_wr_t;

    localparam int PCC_WR_BASE_LO = 0;
    localparam int PCC_WR_BASE_HI = 1;
    localparam int PCC_WR_LEN_LO  = 2;
    localparam int PCC_WR_LEN_HI  = 3;
    localparam int PCC_WR_CUR_LO  = 4;
    localparam int PCC_WR_CUR_HI  = 5;
    localparam int PCC_WR_PERMS   = 6;
    localparam int PCC_WR_ATTR    = 7;
    localparam int PCC_WR_TAG     = 8;

endpackage

`default_nettype wire

// File: verilog/csr_decode.sv
`default_nettype none

module csr_decode (
    input  wire                             csr_we,
    input  wire amber_csr_pkg::csr_idx_t    csr_waddr,
    input  wire amber_csr_pkg::csr_idx_t    csr_raddr,
    input  wire amber_arch_pkg::addr_t      pcc_base,
    input  wire amber_arch_pkg::addr_t      pcc_len,
    input  wire amber_arch_pkg::addr_t      pcc_cur,
    input  wire amber_arch_pkg::data_t      pcc_perms,
    input  wire amber_arch_pkg::data_t      pcc_attr,
    input  wire                             pcc_tag,
    input  wire                             mode_kernel,
    output amber_csr_pkg::pcc_wr_t          pcc_wr,
    output logic                            status_we,
    output amber_arch_pkg::data_t           csr_rdata
);

    logic [9:0] wr_sel;

    // --------------------
    // Write decode
    // --------------------
    always_comb begin
        pcc_wr = '0;
        pcc_wr[amber_csr_pkg::PCC_WR_BASE_LO] = (csr_waddr == amber_csr_pkg::CSR_IDX_PCC_BASE_LO);
        pcc_wr[amber_csr_pkg::PCC_WR_BASE_HI] = (csr_waddr == amber_csr_pkg::CSR_IDX_PCC_BASE_HI);
        pcc_wr[amber_csr_pkg::PCC_WR_LEN_LO]  = (csr_waddr == amber_csr_pkg::CSR_IDX_PCC_LEN_LO);
        pcc_wr[amber_csr_pkg::PCC_WR_LEN_HI]  = (csr_waddr == amber_csr_pkg::CSR_IDX_PCC_LEN_HI);
        pcc_wr[amber_csr_pkg::PCC_WR_CUR_LO]  = (csr_waddr == amber_csr_pkg::CSR_IDX_PCC_CUR_LO);
        pcc_wr[amber_csr_pkg::PCC_WR_CUR_HI]  = (csr_waddr == amber_csr_pkg::CSR_IDX_PCC_CUR_HI);
        pcc_wr[amber_csr_pkg::PCC_WR_PERMS]   = (csr_waddr == amber_csr_pkg::CSR_IDX_PCC_PERMS);
        pcc_wr[amber_csr_pkg::PCC_WR_ATTR]    = (csr_waddr == amber_csr_pkg::CSR_IDX_PCC_ATTR);
        pcc_wr[amber_csr_pkg::PCC_WR_TAG]     = (csr_waddr == amber_csr_pkg::CSR_IDX_PCC_TAG);
        // No strobe fires without a write
        pcc_wr = pcc_wr & {$bits(pcc_wr){csr_we}};
    end

    // Mode gating happens in priv_mode
    assign status_we = csr_we && (csr_waddr == amber_csr_pkg::CSR_IDX_STATUS);

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        case (csr_raddr)
            amber_csr_pkg::CSR_IDX_STATUS:      csr_rdata = amber_arch_pkg::data_t'(mode_kernel);
            amber_csr_pkg::CSR_IDX_PCC_BASE_LO: csr_rdata = pcc_base[23:0];
            amber_csr_pkg::CSR_IDX_PCC_BASE_HI: csr_rdata = pcc_base[47:24];
            amber_csr_pkg::CSR_IDX_PCC_LEN_LO:  csr_rdata = pcc_len[23:0];
            amber_csr_pkg::CSR_IDX_PCC_LEN_HI:  csr_rdata = pcc_len[47:24];
            amber_csr_pkg::CSR_IDX_PCC_CUR_LO:  csr_rdata = pcc_cur[23:0];
            amber_csr_pkg::CSR_IDX_PCC_CUR_HI:  csr_rdata = pcc_cur[47:24];
            amber_csr_pkg::CSR_IDX_PCC_PERMS:   csr_rdata = pcc_perms;
            amber_csr_pkg::CSR_IDX_PCC_ATTR:    csr_rdata = pcc_attr;
            amber_csr_pkg::CSR_IDX_PCC_TAG:     csr_rdata = amber_arch_pkg::data_t'(pcc_tag);
            default:                            csr_rdata = '0;
        endcase
    end

    // At most one register in the core takes any CSR write
    assign wr_sel = {status_we, pcc_wr};

    a_wr_onehot0: assert property (@(wr_sel) $onehot0(wr_sel));

endmodule

`default_nettype wire

// File: verilog/pcc_window.sv
`default_nettype none

module pcc_window (
    input  wire                             iw_clk,
    input  wire                             iw_rst,
    input  wire amber_csr_pkg::pcc_wr_t     pcc_wr,
    input  wire amber_arch_pkg::data_t      csr_wdata,
    input  wire amber_arch_pkg::addr_t      pc,
    output amber_arch_pkg::addr_t           pcc_base,
    output amber_arch_pkg::addr_t           pcc_len,
    output amber_arch_pkg::addr_t           pcc_cur,
    output amber_arch_pkg::data_t           pcc_perms,
    output amber_arch_pkg::data_t           pcc_attr,
    output logic                            pcc_tag,
    output logic                            fetch_ok
);

    logic in_bounds;

    // --------------------
    // Window bounds
    // --------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pcc_base <= '0;
            pcc_len  <= amber_arch_pkg::PCC_LEN_RESET;
        end else begin
            if (pcc_wr[amber_csr_pkg::PCC_WR_BASE_LO])
                pcc_base[23:0] <= csr_wdata;
            if (pcc_wr[amber_csr_pkg::PCC_WR_BASE_HI])
                pcc_base[47:24] <= csr_wdata;
            if (pcc_wr[amber_csr_pkg::PCC_WR_LEN_LO])
                pcc_len[23:0] <= csr_wdata;
            if (pcc_wr[amber_csr_pkg::PCC_WR_LEN_HI])
                pcc_len[47:24] <= csr_wdata;
        end
    end

    // Cursor follows the PC, a direct write to one half takes that half
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pcc_cur <= '0;
        end else begin
            pcc_cur <= pc;
            if (pcc_wr[amber_csr_pkg::PCC_WR_CUR_LO])
                pcc_cur[23:0] <= csr_wdata;
            if (pcc_wr[amber_csr_pkg::PCC_WR_CUR_HI])
                pcc_cur[47:24] <= csr_wdata;
        end
    end

    // --------------------
    // Perms, attributes, tag
    // --------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pcc_perms <= amber_arch_pkg::PCC_PERMS_RESET;
            pcc_attr  <= '0;
            pcc_tag   <= 1'b1;
        end else begin
            if (pcc_wr[amber_csr_pkg::PCC_WR_PERMS])
                pcc_perms <= csr_wdata;
            if (pcc_wr[amber_csr_pkg::PCC_WR_ATTR])
                pcc_attr <= csr_wdata;
            if (pcc_wr[amber_csr_pkg::PCC_WR_TAG])
                pcc_tag <= csr_wdata[0];
        end
    end

    // Upper bound is exclusive
    assign in_bounds = (pc >= pcc_base) && (pc < pcc_base + pcc_len);
    assign fetch_ok  = pcc_tag && pcc_perms[amber_arch_pkg::PERM_X_BIT] && in_bounds;

endmodule

`default_nettype wire

// File: verilog/priv_mode.sv
`default_nettype none

module priv_mode (
    input  wire                             iw_clk,
    input  wire                             iw_rst,
    input  wire amber_arch_pkg::opc_t       ex_opc,
    input  wire                             status_we,
    input  wire amber_arch_pkg::data_t      csr_wdata,
    output logic                            mode_kernel
);

    typedef enum logic {
        USER   = 1'b0,
        KERNEL = 1'b1
    } mode_e;

    mode_e state;
    mode_e state_nxt;

    always_comb begin
        state_nxt = state;
        if (ex_opc == amber_arch_pkg::OPC_SWI)
            state_nxt = KERNEL;
        else if (ex_opc == amber_arch_pkg::OPC_SRET)
            state_nxt = USER;
        // STATUS write only honoured in kernel, beats the opcode
        if (status_we && (state == KERNEL))
            state_nxt = csr_wdata[0] ? KERNEL : USER;
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst)
            state <= KERNEL;
        else
            state <= state_nxt;
    end

    assign mode_kernel = (state == KERNEL);

    a_swi_kernel: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (ex_opc == amber_arch_pkg::OPC_SWI) && !status_we |=> state == KERNEL);

endmodule

`default_nettype wire

// File: verilog/pc_sequencer.sv
`default_nettype none

module pc_sequencer (
    input  wire                             iw_clk,
    input  wire                             iw_rst,
    input  wire                             branch_taken,
    input  wire amber_arch_pkg::addr_t      branch_pc,
    input  wire                             hazard_stall,
    input  wire                             ic_stall,
    input  wire                             dc_stall,
    input  wire                             fetch_ok,
    output amber_arch_pkg::addr_t           pc
);

    logic stall;

    // Hazard and both cache refills hold fetch alike
    assign stall = hazard_stall | ic_stall | dc_stall;

    // --------------------
    // PC register
    // --------------------
    // Priority is branch, then stall, then advance
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_pc;
        end else if (!stall && fetch_ok) begin
            pc <= pc + amber_arch_pkg::addr_t'(1);
        end
        // otherwise hold, a PCC violation parks the PC
    end

    a_stall_hold: assert property (@(posedge iw_clk) disable iff (iw_rst)
        stall && !branch_taken |=> $stable(pc));

endmodule

`default_nettype wire

// File: verilog/fetch_guard.sv
`default_nettype none

module fetch_guard (
    input  wire                             iw_clk,
    input  wire                             iw_rst,
    input  wire                             csr_we,
    input  wire amber_csr_pkg::csr_idx_t    csr_waddr,
    input  wire amber_arch_pkg::data_t      csr_wdata,
    input  wire amber_arch_pkg::opc_t       ex_opc,
    input  wire                             branch_taken,
    input  wire amber_arch_pkg::addr_t      branch_pc,
    input  wire                             hazard_stall,
    input  wire                             ic_stall,
    input  wire                             dc_stall,
    input  wire amber_csr_pkg::csr_idx_t    csr_raddr,
    output wire amber_arch_pkg::addr_t      pc,
    output wire                             fetch_ok,
    output wire                             mode_kernel,
    output wire amber_arch_pkg::data_t      csr_rdata
);

    wire amber_csr_pkg::pcc_wr_t    pcc_wr;
    wire                            status_we;
    wire amber_arch_pkg::addr_t     pcc_base;
    wire amber_arch_pkg::addr_t     pcc_len;
    wire amber_arch_pkg::addr_t     pcc_cur;
    wire amber_arch_pkg::data_t     pcc_perms;
    wire amber_arch_pkg::data_t     pcc_attr;
    wire                            pcc_tag;

    csr_decode u_csr_decode (
        .csr_we      (csr_we),
        .csr_waddr   (csr_waddr),
        .csr_raddr   (csr_raddr),
        .pcc_base    (pcc_base),
        .pcc_len     (pcc_len),
        .pcc_cur     (pcc_cur),
        .pcc_perms   (pcc_perms),
        .pcc_attr    (pcc_attr),
        .pcc_tag     (pcc_tag),
        .mode_kernel (mode_kernel),
        .pcc_wr      (pcc_wr),
        .status_we   (status_we),
        .csr_rdata   (csr_rdata)
    );

    pcc_window u_pcc_window (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .pcc_wr      (pcc_wr),
        .csr_wdata   (csr_wdata),
        .pc          (pc),
        .pcc_base    (pcc_base),
        .pcc_len     (pcc_len),
        .pcc_cur     (pcc_cur),
        .pcc_perms   (pcc_perms),
        .pcc_attr    (pcc_attr),
        .pcc_tag     (pcc_tag),
        .fetch_ok    (fetch_ok)
    );

    priv_mode u_priv_mode (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .ex_opc      (ex_opc),
        .status_we   (status_we),
        .csr_wdata   (csr_wdata),
        .mode_kernel (mode_kernel)
    );

    pc_sequencer u_pc_sequencer (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .hazard_stall (hazard_stall),
        .ic_stall     (ic_stall),
        .dc_stall     (dc_stall),
        .fetch_ok     (fetch_ok),
        .pc           (pc)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic iw_clk,
    output logic iw_rst
);

    initial begin
        iw_clk = 1'b0;
        forever #5 iw_clk = ~iw_clk;
    end

    // Reset held over three rising edges
    initial begin
        iw_rst = 1'b1;
        repeat (3) @(posedge iw_clk);
        iw_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_fetch_guard.sv
`default_nettype none

module tb_fetch_guard;

    // Tests run about 1500 cycles
    localparam int CYCLE_LIMIT = 2000;

    wire                        iw_clk;
    wire                        iw_rst;
    logic                       csr_we;
    amber_csr_pkg::csr_idx_t    csr_waddr;
    amber_arch_pkg::data_t      csr_wdata;
    amber_arch_pkg::opc_t       ex_opc;
    logic                       branch_taken;
    amber_arch_pkg::addr_t      branch_pc;
    logic                       hazard_stall;
    logic                       ic_stall;
    logic                       dc_stall;
    amber_csr_pkg::csr_idx_t    csr_raddr;
    amber_arch_pkg::addr_t      pc;
    logic                       fetch_ok;
    logic                       mode_kernel;
    amber_arch_pkg::data_t      csr_rdata;

    // --------------------
    // Reference model state
    // --------------------
    amber_arch_pkg::addr_t      m_pc = '0;
    amber_arch_pkg::addr_t      m_base = '0;
    amber_arch_pkg::addr_t      m_len = 48'd4096;
    amber_arch_pkg::addr_t      m_cur = '0;
    amber_arch_pkg::data_t      m_perms = 24'd4;
    amber_arch_pkg::data_t      m_attr = '0;
    logic                       m_tag = 1'b1;
    logic                       m_kernel = 1'b1;

    logic [15:0]                lfsr = 16'd59;
    int                         checks = 0;
    int                         errors = 0;
    int                         cycles = 0;

    tb_clk_gen u_clk_gen (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst)
    );

    fetch_guard uut (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [47:0] rand_bits(input int n);
        logic [47:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[46:0], lfsr[15]};
        end
        return v;
    endfunction

    function automatic logic model_fetch_ok();
        return m_tag && m_perms[amber_arch_pkg::PERM_X_BIT] &&
            (m_pc >= m_base) && (m_pc < m_base + m_len);
    endfunction

    function automatic amber_arch_pkg::data_t model_read(input amber_csr_pkg::csr_idx_t idx);
        case (idx)
            amber_csr_pkg::CSR_IDX_STATUS:      return {23'd0, m_kernel};
            amber_csr_pkg::CSR_IDX_PCC_BASE_LO: return m_base[23:0];
            amber_csr_pkg::CSR_IDX_PCC_BASE_HI: return m_base[47:24];
            amber_csr_pkg::CSR_IDX_PCC_LEN_LO:  return m_len[23:0];
            amber_csr_pkg::CSR_IDX_PCC_LEN_HI:  return m_len[47:24];
            amber_csr_pkg::CSR_IDX_PCC_CUR_LO:  return m_cur[23:0];
            amber_csr_pkg::CSR_IDX_PCC_CUR_HI:  return m_cur[47:24];
            amber_csr_pkg::CSR_IDX_PCC_PERMS:   return m_perms;
            amber_csr_pkg::CSR_IDX_PCC_ATTR:    return m_attr;
            amber_csr_pkg::CSR_IDX_PCC_TAG:     return {23'd0, m_tag};
            default:                            return '0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [47:0] got, input logic [47:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic read_check(input amber_csr_pkg::csr_idx_t idx, input amber_arch_pkg::data_t exp);
        csr_raddr = idx;
        #1;
        check_val($sformatf("csr_rdata[%h]", idx), csr_rdata, exp);
    endtask

    // --------------------
    // One cycle: drive, step the model, check after the edge
    // --------------------
    task automatic step(input logic we, input amber_csr_pkg::csr_idx_t wa,
                        input amber_arch_pkg::data_t wd, input amber_arch_pkg::opc_t opc,
                        input logic br, input amber_arch_pkg::addr_t bpc,
                        input logic [2:0] st, input amber_csr_pkg::csr_idx_t ra);
        logic fok;
        logic k;
        csr_we = we;
        csr_waddr = wa;
        csr_wdata = wd;
        ex_opc = opc;
        branch_taken = br;
        branch_pc = bpc;
        {hazard_stall, ic_stall, dc_stall} = st;
        csr_raddr = ra;
        fok = model_fetch_ok();
        k = m_kernel;
        if (opc == amber_arch_pkg::OPC_SWI)
            k = 1'b1;
        else if (opc == amber_arch_pkg::OPC_SRET)
            k = 1'b0;
        if (we && wa == amber_csr_pkg::CSR_IDX_STATUS && m_kernel)
            k = wd[0];
        m_cur = m_pc;
        if (we) begin
            case (wa)
                amber_csr_pkg::CSR_IDX_PCC_BASE_LO: m_base[23:0] = wd;
                amber_csr_pkg::CSR_IDX_PCC_BASE_HI: m_base[47:24] = wd;
                amber_csr_pkg::CSR_IDX_PCC_LEN_LO:  m_len[23:0] = wd;
                amber_csr_pkg::CSR_IDX_PCC_LEN_HI:  m_len[47:24] = wd;
                amber_csr_pkg::CSR_IDX_PCC_CUR_LO:  m_cur[23:0] = wd;
                amber_csr_pkg::CSR_IDX_PCC_CUR_HI:  m_cur[47:24] = wd;
                amber_csr_pkg::CSR_IDX_PCC_PERMS:   m_perms = wd;
                amber_csr_pkg::CSR_IDX_PCC_ATTR:    m_attr = wd;
                amber_csr_pkg::CSR_IDX_PCC_TAG:     m_tag = wd[0];
                default: ;
            endcase
        end
        if (br)
            m_pc = bpc;
        else if (st == 3'b000 && fok)
            m_pc = m_pc + 48'd1;
        m_kernel = k;
        @(negedge iw_clk);
        check_val("pc", pc, m_pc);
        check_val("fetch_ok", fetch_ok, model_fetch_ok());
        check_val("mode_kernel", mode_kernel, m_kernel);
        check_val($sformatf("csr_rdata[%h]", ra), csr_rdata, model_read(ra));
    endtask

    task automatic write_csr(input amber_csr_pkg::csr_idx_t idx, input amber_arch_pkg::data_t d);
        step(1'b1, idx, d, 8'h00, 1'b0, '0, 3'b001, idx);
    endtask

    // Test 2 branch/stall, 3 window writes, 4 cursor, 5 privilege
    task automatic run_test(input int t, input int n);
        logic [47:0] r;
        logic we;
        amber_csr_pkg::csr_idx_t wa;
        amber_arch_pkg::data_t wd;
        amber_arch_pkg::opc_t opc;
        logic [2:0] st;
        amber_csr_pkg::csr_idx_t ra;
        for (int i = 0; i < n; i++) begin
            r = rand_bits(40);
            we = 1'b0;
            wa = amber_csr_pkg::CSR_IDX_STATUS;
            wd = amber_arch_pkg::data_t'(r[10:5]);
            opc = 8'h00;
            st = r[25:23] & r[28:26];
            ra = amber_csr_pkg::CSR_IDX_STATUS;
            case (t)
                3: begin
                    // Small base and length so the PC walks out of the window
                    we = r[0];
                    wa = 8'h10 + r[4:1];
                    if (wa[0] && wa <= amber_csr_pkg::CSR_IDX_PCC_CUR_HI)
                        wd = (r[12:11] == 2'd0) ? 24'd1 : 24'd0;
                    ra = 8'h10 + r[32:29];
                end
                4: begin
                    we = (r[2:0] == 3'd0);
                    wa = amber_csr_pkg::CSR_IDX_PCC_CUR_LO + r[3];
                    ra = amber_csr_pkg::CSR_IDX_PCC_CUR_LO + (r[32:31] == 2'd0);
                end
                5: begin
                    we = (r[11:10] == 2'd0);
                    wd = amber_arch_pkg::data_t'(r[12]);
                    opc = (r[1:0] == 2'd0) ? amber_arch_pkg::OPC_SWI :
                          (r[1:0] == 2'd1) ? amber_arch_pkg::OPC_SRET : r[20:13];
                    st = 3'b000;
                end
                default: ;
            endcase
            step(we, wa, wd, opc, r[15:13] == 3'd0 && t != 5,
                 amber_arch_pkg::addr_t'(r[22:16]), st, ra);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s: %s, %0d errors", name,
                 (errors == errs_before) ? "ok" : "mismatches", errors - errs_before);
    endtask

    always @(posedge iw_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int e0;
        csr_we = 1'b0;
        csr_waddr = '0;
        csr_wdata = '0;
        ex_opc = '0;
        branch_taken = 1'b0;
        branch_pc = '0;
        hazard_stall = 1'b1;
        ic_stall = 1'b0;
        dc_stall = 1'b0;
        csr_raddr = '0;
        wait (iw_rst === 1'b0);
        @(negedge iw_clk);

        e0 = errors;
        check_val("pc", pc, 48'd0);
        check_val("mode_kernel", mode_kernel, 1'b1);
        check_val("fetch_ok", fetch_ok, 1'b1);
        read_check(amber_csr_pkg::CSR_IDX_STATUS, 24'd1);
        read_check(amber_csr_pkg::CSR_IDX_PCC_LEN_LO, 24'd4096);
        read_check(amber_csr_pkg::CSR_IDX_PCC_LEN_HI, 24'd0);
        read_check(amber_csr_pkg::CSR_IDX_PCC_PERMS, 24'd4);
        report_test("reset values", e0);
        @(negedge iw_clk);

        e0 = errors;
        run_test(2, 400);
        report_test("branch and stall", e0);
        e0 = errors;
        run_test(3, 500);
        report_test("pcc window", e0);

        // Back to the reset window so the PC runs again
        e0 = errors;
        write_csr(amber_csr_pkg::CSR_IDX_PCC_BASE_LO, 24'd0);
        write_csr(amber_csr_pkg::CSR_IDX_PCC_BASE_HI, 24'd0);
        write_csr(amber_csr_pkg::CSR_IDX_PCC_LEN_LO, 24'd4096);
        write_csr(amber_csr_pkg::CSR_IDX_PCC_LEN_HI, 24'd0);
        write_csr(amber_csr_pkg::CSR_IDX_PCC_PERMS, 24'd4);
        write_csr(amber_csr_pkg::CSR_IDX_PCC_TAG, 24'd1);
        step(1'b0, amber_csr_pkg::CSR_IDX_STATUS, '0, 8'h00, 1'b1, '0, 3'b000,
             amber_csr_pkg::CSR_IDX_PCC_TAG);
        run_test(4, 300);
        report_test("cursor", e0);
        e0 = errors;
        run_test(5, 300);
        report_test("privilege", e0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/amber_arch_pkg.sv
verilog/amber_csr_pkg.sv
verilog/csr_decode.sv
verilog/pcc_window.sv
verilog/priv_mode.sv
verilog/pc_sequencer.sv
verilog/fetch_guard.sv
testbench/tb_clk_gen.sv
testbench/tb_fetch_guard.sv

// File: Bender.yml
package:
  name: fetch_guard

sources:
  - verilog/amber_arch_pkg.sv
  - verilog/amber_csr_pkg.sv
  - verilog/csr_decode.sv
  - verilog/pcc_window.sv
  - verilog/priv_mode.sv
  - verilog/pc_sequencer.sv
  - verilog/fetch_guard.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_fetch_guard.sv
